// File: verilog/memory_pkg.sv
// Memory package with the shared line address, strobe, command and status types

package memory_pkg;

  // Cache line address width in bits
  localparam int unsigned LINE_ADDR_W = 26;

  // Cache line address
  typedef logic [LINE_ADDR_W-1:0] line_addr_t;

  // Miss strobe from the cache pipeline
  typedef struct packed {
    logic       valid;
    line_addr_t line_addr;
  } miss_req_t;

  // Refill strobe from the L2 cache
  typedef struct packed {
    logic       valid;
    line_addr_t line_addr;
  } refill_t;

  // Outcome of a miss
  typedef enum logic [1:0] {
    MISS_ALLOCATED = 2'd0,
    MISS_MERGED    = 2'd1,
    MISS_REJECTED  = 2'd2
  } miss_status_e;

  // Answer to the pipeline for each miss
  typedef struct packed {
    logic         valid;
    miss_status_e status;
  } miss_resp_t;

  // Command from the intake to the MSHR
  // Address is compared every cycle and stored on add
  typedef struct packed {
    logic       add;
    logic       clear_hit;
    line_addr_t line_addr;
  } mshr_cmd_t;

  // Line request to the L2 cache
  typedef struct packed {
    logic       valid;
    line_addr_t line_addr;
  } l2_req_t;

endpackage

// File: verilog/priority_index_encoder.sv
// Priority index encoder giving the position of the lowest set bit of a vector

`timescale 1ns/10ps

module priority_index_encoder #(
  parameter int unsigned WIDTH = 4
) (
  input  logic [WIDTH-1:0]         vec_i,
  output logic [$clog2(WIDTH)-1:0] index_o,
  output logic                     any_o
);

  localparam int unsigned IDX_W = $clog2(WIDTH);

  // Scan from the top down so the lowest set bit is written last and wins
  always_comb begin
    index_o = '0;
    for (int k = WIDTH - 1; k >= 0; k--) begin
      if (vec_i[k]) begin
        index_o = IDX_W'(k);
      end
    end
  end

  // Index is only meaningful when some bit is set
  assign any_o = |vec_i;

endmodule

// File: verilog/dcache_mshr.sv
// MSHR entry file tracking outstanding L1 data cache line misses

`timescale 1ns/10ps

module dcache_mshr #(
  parameter int unsigned MSHR_ENTRIES = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  memory_pkg::mshr_cmd_t         cmd_i,
  input  logic                          put_wait_i,
  output logic                          hit_o,
  output logic                          full_o,
  output logic                          req_available_o,
  output memory_pkg::line_addr_t        next_line_addr_o,
  output logic [$clog2(MSHR_ENTRIES):0] pending_o
);

  import memory_pkg::*;

  localparam int unsigned IDX_W = $clog2(MSHR_ENTRIES);
  localparam int unsigned CNT_W = IDX_W + 1;

  // Entry storage
  line_addr_t              line_addr_q [MSHR_ENTRIES];
  logic [MSHR_ENTRIES-1:0] valid_q;
  logic [MSHR_ENTRIES-1:0] wait_q;

  // Selection vectors
  logic [MSHR_ENTRIES-1:0] free_vec;
  logic [MSHR_ENTRIES-1:0] ready_vec;
  logic [MSHR_ENTRIES-1:0] hit_vec;
  logic [MSHR_ENTRIES-1:0] pend_vec;

  // Encoded entry indices
  logic [IDX_W-1:0] free_idx;
  logic [IDX_W-1:0] next_idx;
  logic [IDX_W-1:0] hit_idx;
  logic             free_any;

  // Free entries are the invalid ones
  assign free_vec = ~valid_q;

  // Ready to request means allocated but not yet sent to L2
  assign ready_vec = valid_q & ~wait_q;

  // Requested and still waiting for the refill
  assign pend_vec = valid_q & wait_q;

  // Compare the command line address with every valid entry
  always_comb begin
    for (int k = 0; k < MSHR_ENTRIES; k++) begin
      hit_vec[k] = valid_q[k] && (cmd_i.line_addr == line_addr_q[k]);
    end
  end

  priority_index_encoder #(
    .WIDTH (MSHR_ENTRIES)
  ) i_free_encoder (
    .vec_i   (free_vec),
    .index_o (free_idx),
    .any_o   (free_any)
  );

  priority_index_encoder #(
    .WIDTH (MSHR_ENTRIES)
  ) i_next_encoder (
    .vec_i   (ready_vec),
    .index_o (next_idx),
    .any_o   (req_available_o)
  );

  priority_index_encoder #(
    .WIDTH (MSHR_ENTRIES)
  ) i_hit_encoder (
    .vec_i   (hit_vec),
    .index_o (hit_idx),
    .any_o   (hit_o)
  );

  // State bits, flush first, then add, put-wait and clear-hit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      wait_q  <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
      wait_q  <= '0;
    end else if (cmd_i.add) begin
      valid_q[free_idx] <= 1'b1;
      wait_q[free_idx]  <= 1'b0;
    end else if (put_wait_i) begin
      wait_q[next_idx] <= 1'b1;
    end else if (cmd_i.clear_hit && hit_o) begin
      // Refill with no matching entry leaves the file untouched
      valid_q[hit_idx] <= 1'b0;
      wait_q[hit_idx]  <= 1'b0;
    end
  end

  // Line address payload, written only on allocation
  always_ff @(posedge clk_i) begin
    if (!flush_i && cmd_i.add) begin
      line_addr_q[free_idx] <= cmd_i.line_addr;
    end
  end

  // Address of the lowest entry still to be requested
  assign next_line_addr_o = line_addr_q[next_idx];

  // Full when no entry is free
  assign full_o = ~free_any;

  // Count of valid and waiting entries
  always_comb begin
    pending_o = '0;
    for (int k = 0; k < MSHR_ENTRIES; k++) begin
      pending_o = pending_o + CNT_W'(pend_vec[k]);
    end
  end

endmodule

// File: verilog/miss_intake.sv
// Miss intake that registers miss and refill strobes and drives one MSHR command

`timescale 1ns/10ps

module miss_intake (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  memory_pkg::miss_req_t  miss_i,
  input  memory_pkg::refill_t    refill_i,
  input  logic                   hit_i,
  input  logic                   full_i,
  output memory_pkg::mshr_cmd_t  cmd_o,
  output logic                   slot_busy_o,
  output memory_pkg::miss_resp_t miss_resp_o
);

  import memory_pkg::*;

  // Operation slot
  logic       slot_valid_q;
  logic       slot_refill_q;
  line_addr_t slot_addr_q;

  // Slot control, a flush drops both the held and the arriving strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_valid_q  <= 1'b0;
      slot_refill_q <= 1'b0;
    end else if (flush_i) begin
      slot_valid_q  <= 1'b0;
      slot_refill_q <= 1'b0;
    end else begin
      slot_valid_q  <= miss_i.valid | refill_i.valid;
      // Miss wins if both arrive, the environment never sends both
      slot_refill_q <= ~miss_i.valid & refill_i.valid;
    end
  end

  // Slot address payload
  always_ff @(posedge clk_i) begin
    if (miss_i.valid) begin
      slot_addr_q <= miss_i.line_addr;
    end else if (refill_i.valid) begin
      slot_addr_q <= refill_i.line_addr;
    end
  end

  // MSHR command
  always_comb begin
    cmd_o.line_addr = slot_addr_q;
    // Allocate only a new line while an entry is free
    cmd_o.add       = slot_valid_q & ~slot_refill_q & ~hit_i & ~full_i;
    // Refill frees the matching entry
    cmd_o.clear_hit = slot_valid_q & slot_refill_q;
  end

  // Any held strobe occupies the MSHR this cycle
  assign slot_busy_o = slot_valid_q;

  // Miss response, same cycle as the command
  always_comb begin
    miss_resp_o.valid = slot_valid_q & ~slot_refill_q & ~flush_i;
    if (hit_i) begin
      miss_resp_o.status = MISS_MERGED;
    end else if (full_i) begin
      miss_resp_o.status = MISS_REJECTED;
    end else begin
      miss_resp_o.status = MISS_ALLOCATED;
    end
  end

endmodule

// File: verilog/l2_request_issuer.sv
// L2 request issuer sending one line request per allocated MSHR entry in idle cycles

`timescale 1ns/10ps

module l2_request_issuer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic                   slot_busy_i,
  input  logic                   req_available_i,
  input  memory_pkg::line_addr_t next_line_addr_i,
  output logic                   put_wait_o,
  output memory_pkg::l2_req_t    l2_req_o,
  output logic [15:0]            issued_count_o
);

  logic        issue;
  logic [15:0] issued_count_q;

  // MSHR is granted to the issuer only when the intake leaves it idle
  // Flush empties the file, so nothing is sent in that cycle
  assign issue = req_available_i & ~slot_busy_i & ~flush_i;

  // Mark the entry waiting in the same cycle as the request leaves
  assign put_wait_o = issue;

  // Line request to L2
  always_comb begin
    l2_req_o.valid     = issue;
    l2_req_o.line_addr = next_line_addr_i;
  end

  // Issued request counter for performance statistics
  // Wraps at 16 bits and keeps counting across flushes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_count_q <= '0;
    end else if (issue) begin
      issued_count_q <= issued_count_q + 16'd1;
    end
  end

  assign issued_count_o = issued_count_q;

endmodule

// File: verilog/dcache_miss_unit.sv
// L1 data cache miss unit joining the intake, the MSHR and the L2 request issuer

`timescale 1ns/10ps

module dcache_miss_unit #(
  parameter int unsigned MSHR_ENTRIES = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  memory_pkg::miss_req_t         miss_i,
  input  memory_pkg::refill_t           refill_i,
  output memory_pkg::miss_resp_t        miss_resp_o,
  output memory_pkg::l2_req_t           l2_req_o,
  output logic                          full_o,
  output logic [$clog2(MSHR_ENTRIES):0] pending_o,
  output logic [15:0]                   issued_count_o
);

  import memory_pkg::*;

  // Intake to MSHR
  mshr_cmd_t  mshr_cmd;
  logic       slot_busy;

  // MSHR status
  logic       hit;
  logic       req_available;
  line_addr_t next_line_addr;

  // Issuer to MSHR
  logic       put_wait;

  miss_intake i_miss_intake (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .miss_i      (miss_i),
    .refill_i    (refill_i),
    .hit_i       (hit),
    .full_i      (full_o),
    .cmd_o       (mshr_cmd),
    .slot_busy_o (slot_busy),
    .miss_resp_o (miss_resp_o)
  );

  dcache_mshr #(
    .MSHR_ENTRIES (MSHR_ENTRIES)
  ) i_dcache_mshr (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .cmd_i            (mshr_cmd),
    .put_wait_i       (put_wait),
    .hit_o            (hit),
    .full_o           (full_o),
    .req_available_o  (req_available),
    .next_line_addr_o (next_line_addr),
    .pending_o        (pending_o)
  );

  l2_request_issuer i_l2_request_issuer (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .flush_i          (flush_i),
    .slot_busy_i      (slot_busy),
    .req_available_i  (req_available),
    .next_line_addr_i (next_line_addr),
    .put_wait_o       (put_wait),
    .l2_req_o         (l2_req_o),
    .issued_count_o   (issued_count_o)
  );

endmodule

// File: testbench/tb_dcache_miss_unit.sv
// Testbench for the L1 data cache miss unit against a cycle-level reference model

`timescale 1ns/10ps

module tb_dcache_miss_unit;

  import memory_pkg::*;

  localparam int unsigned ENTRIES    = 4;
  localparam int unsigned CNT_W      = $clog2(ENTRIES) + 1;
  localparam int unsigned MAX_CYCLES = 4000;
  localparam int unsigned RANDOM_OPS = 500;
  localparam line_addr_t  LINE_BASE  = 26'h00abc0;

  logic             clk_i;
  logic             rst_ni;
  logic             flush_i;
  miss_req_t        miss_i;
  refill_t          refill_i;
  miss_resp_t       miss_resp_o;
  l2_req_t          l2_req_o;
  logic             full_o;
  logic [CNT_W-1:0] pending_o;
  logic [15:0]      issued_count_o;

  // Reference model state for each MSHR entry and the registered strobe
  logic        ref_valid [ENTRIES];
  logic        ref_wait  [ENTRIES];
  line_addr_t  ref_addr  [ENTRIES];
  logic        ref_slot_valid;
  logic        ref_slot_refill;
  line_addr_t  ref_slot_addr;
  logic [15:0] ref_issued;

  int unsigned cycle_count = 0;

  dcache_miss_unit #(
    .MSHR_ENTRIES (ENTRIES)
  ) i_dcache_miss_unit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .miss_i         (miss_i),
    .refill_i       (refill_i),
    .miss_resp_o    (miss_resp_o),
    .l2_req_o       (l2_req_o),
    .full_o         (full_o),
    .pending_o      (pending_o),
    .issued_count_o (issued_count_o)
  );

  always #5 clk_i = ~clk_i;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected === actual)
      else abort_run($sformatf("FAIL %s expected %0h actual %0h", name, expected, actual));
  endtask

  // Small set of line addresses so that merges and refill hits are frequent
  function automatic line_addr_t line_of(input int k);
    return LINE_BASE + line_addr_t'(k);
  endfunction

  // Inputs back to idle for n cycles
  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      miss_i   <= '0;
      refill_i <= '0;
      flush_i  <= 1'b0;
    end
  endtask

  task automatic send_miss(input line_addr_t addr);
    @(posedge clk_i);
    miss_i.valid     <= 1'b1;
    miss_i.line_addr <= addr;
    idle(1);
  endtask

  task automatic send_refill(input line_addr_t addr);
    @(posedge clk_i);
    refill_i.valid     <= 1'b1;
    refill_i.line_addr <= addr;
    idle(1);
  endtask

  task automatic send_flush();
    @(posedge clk_i);
    flush_i <= 1'b1;
    idle(1);
  endtask

  // Flush lands in the cycle where the miss sits in the intake slot
  task automatic send_miss_then_flush(input line_addr_t addr);
    @(posedge clk_i);
    miss_i.valid     <= 1'b1;
    miss_i.line_addr <= addr;
    @(posedge clk_i);
    miss_i  <= '0;
    flush_i <= 1'b1;
    idle(1);
  endtask

  // Response is due one cycle after the strobe
  task automatic expect_miss(input string name, input line_addr_t addr,
                             input miss_status_e status);
    send_miss(addr);
    @(negedge clk_i);
    check_value({name, "_valid"}, 32'd1, 32'(miss_resp_o.valid));
    check_value({name, "_status"}, 32'(status), 32'(miss_resp_o.status));
  endtask

  // Request latency varies, so wait for the valid bit with a bound
  task automatic wait_l2_request(input string name, input line_addr_t addr);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!l2_req_o.valid && waited < 16) begin
      @(negedge clk_i);
      waited++;
    end
    if (l2_req_o.valid) begin
      check_value(name, 32'(addr), 32'(l2_req_o.line_addr));
    end else begin
      abort_run($sformatf("No L2 request appeared within 16 cycles in test %s", name));
    end
  endtask

  task automatic check_occupancy(input string name, input int pending, input logic full);
    check_value({name, "_pending"}, 32'(pending), 32'(pending_o));
    check_value({name, "_full"}, 32'(full), 32'(full_o));
  endtask

  // Reference model compared and stepped once per cycle on the falling edge
  always @(negedge clk_i) begin
    int           hit_idx;
    int           free_idx;
    int           ready_idx;
    int           pend;
    logic         exp_resp;
    logic         exp_issue;
    miss_status_e exp_status;
    hit_idx   = -1;
    free_idx  = -1;
    ready_idx = -1;
    pend      = 0;
    if (!rst_ni) begin
      for (int k = 0; k < ENTRIES; k++) begin
        ref_valid[k] = 1'b0;
        ref_wait[k]  = 1'b0;
        ref_addr[k]  = '0;
      end
      ref_slot_valid  = 1'b0;
      ref_slot_refill = 1'b0;
      ref_slot_addr   = '0;
      ref_issued      = '0;
    end else begin
      // Lowest matching, lowest free and lowest unrequested line
      for (int k = 0; k < ENTRIES; k++) begin
        if (ref_valid[k] && ref_addr[k] == ref_slot_addr && hit_idx < 0) hit_idx = k;
        if (!ref_valid[k] && free_idx < 0) free_idx = k;
        if (ref_valid[k] && !ref_wait[k] && ready_idx < 0) ready_idx = k;
        if (ref_valid[k] && ref_wait[k]) pend++;
      end
      exp_resp  = ref_slot_valid && !ref_slot_refill && !flush_i;
      // Requests only go out while no strobe holds the MSHR
      exp_issue = !ref_slot_valid && !flush_i && (ready_idx >= 0);
      if (hit_idx >= 0) begin
        exp_status = MISS_MERGED;
      end else if (free_idx < 0) begin
        exp_status = MISS_REJECTED;
      end else begin
        exp_status = MISS_ALLOCATED;
      end
      check_value("model_resp_valid", 32'(exp_resp), 32'(miss_resp_o.valid));
      if (exp_resp) begin
        check_value("model_resp_status", 32'(exp_status), 32'(miss_resp_o.status));
      end
      check_value("model_l2_valid", 32'(exp_issue), 32'(l2_req_o.valid));
      check_value("model_full", 32'(free_idx < 0), 32'(full_o));
      check_value("model_pending", 32'(pend), 32'(pending_o));
      check_value("model_issued", 32'(ref_issued), 32'(issued_count_o));
      // Entry updates in priority order of flush, allocate, request and refill
      for (int k = 0; k < ENTRIES; k++) begin
        if (exp_issue && k == ready_idx) begin
          check_value("model_l2_addr", 32'(ref_addr[k]), 32'(l2_req_o.line_addr));
        end
        if (flush_i) begin
          ref_valid[k] = 1'b0;
          ref_wait[k]  = 1'b0;
        end else if (exp_resp && hit_idx < 0 && free_idx >= 0) begin
          if (k == free_idx) begin
            ref_valid[k] = 1'b1;
            ref_wait[k]  = 1'b0;
            ref_addr[k]  = ref_slot_addr;
          end
        end else if (exp_issue) begin
          if (k == ready_idx) ref_wait[k] = 1'b1;
        end else if (ref_slot_valid && ref_slot_refill && k == hit_idx) begin
          ref_valid[k] = 1'b0;
          ref_wait[k]  = 1'b0;
        end
      end
      if (exp_issue) ref_issued = ref_issued + 16'd1;
      // Strobe seen this cycle is registered unless a flush drops it
      ref_slot_valid  = !flush_i && (miss_i.valid || refill_i.valid);
      ref_slot_refill = !flush_i && !miss_i.valid && refill_i.valid;
      if (miss_i.valid) begin
        ref_slot_addr = miss_i.line_addr;
      end else if (refill_i.valid) begin
        ref_slot_addr = refill_i.line_addr;
      end
    end
  end

  // Intake and issuer never drive the MSHR in the same cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   !(miss_resp_o.valid && l2_req_o.valid))
    else abort_run("Miss response and L2 request were driven in the same cycle");

  // One cycle after a flush the MSHR is empty
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   $past(flush_i) |-> (pending_o == '0 && !full_o))
    else abort_run("MSHR was not empty in the cycle after a flush");

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > MAX_CYCLES) begin
      abort_run("Timeout, the run did not finish within the cycle limit");
    end
  end

  initial begin
    int         sel;
    line_addr_t addr;
    void'($urandom(32'hdf5e));
    clk_i    = 1'b0;
    rst_ni   = 1'b0;
    flush_i  = 1'b0;
    miss_i   = '0;
    refill_i = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Allocation and a single L2 request
    expect_miss("alloc", line_of(0), MISS_ALLOCATED);
    wait_l2_request("alloc_l2", line_of(0));
    @(negedge clk_i);
    check_value("alloc_issued", 32'd1, 32'(issued_count_o));
    check_occupancy("alloc", 1, 1'b0);

    // Merge sends nothing new
    expect_miss("merge", line_of(0), MISS_MERGED);
    repeat (3) @(negedge clk_i);
    check_value("merge_issued", 32'd1, 32'(issued_count_o));

    // Fill every entry, then reject and merge
    for (int k = 1; k < 4; k++) begin
      expect_miss("fill", line_of(k), MISS_ALLOCATED);
      wait_l2_request("fill_l2", line_of(k));
    end
    @(negedge clk_i);
    check_occupancy("full", 4, 1'b1);
    expect_miss("reject", line_of(4), MISS_REJECTED);
    expect_miss("full_merge", line_of(2), MISS_MERGED);

    // Refill takes effect two cycles after the strobe
    send_refill(line_of(1));
    @(negedge clk_i);
    check_occupancy("refill_early", 4, 1'b1);
    @(negedge clk_i);
    check_occupancy("refill", 3, 1'b0);
    expect_miss("realloc", line_of(4), MISS_ALLOCATED);
    wait_l2_request("realloc_l2", line_of(4));
    send_refill(line_of(5));
    repeat (2) @(negedge clk_i);
    check_occupancy("refill_unknown", 4, 1'b1);

    // Flush empties the file and old lines allocate again
    send_flush();
    @(negedge clk_i);
    check_occupancy("flush", 0, 1'b0);
    expect_miss("after_flush", line_of(1), MISS_ALLOCATED);
    wait_l2_request("after_flush_l2", line_of(1));

    // Held miss gives no response and no entry when a flush arrives
    send_miss_then_flush(line_of(3));
    @(negedge clk_i);
    check_occupancy("flush_held", 0, 1'b0);

    // Random mix weighted toward misses
    for (int n = 0; n < RANDOM_OPS; n++) begin
      sel  = $urandom_range(9, 0);
      addr = line_of($urandom_range(5, 0));
      if (sel < 6) begin
        send_miss(addr);
      end else if (sel < 9) begin
        send_refill(addr);
      end else begin
        send_flush();
      end
      idle($urandom_range(3, 0));
    end
    idle(8);

    @(posedge clk_i);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: sources.f
verilog/memory_pkg.sv
verilog/priority_index_encoder.sv
verilog/dcache_mshr.sv
verilog/miss_intake.sv
verilog/l2_request_issuer.sv
verilog/dcache_miss_unit.sv
testbench/tb_dcache_miss_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the miss unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f sources.f --top-module tb_dcache_miss_unit \
  --Mdir obj_dir -o tb_sim

# The simulator exits non-zero on a fatal error, the output search decides
sim_out=$(./obj_dir/tb_sim) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1
